// File: src/snakeGeometryPkg.sv
/*
 * Screen geometry shared by the snake engine: coordinate types, screen size,
 * start and apple positions, and the steering direction encoding.
 */
package snakeGeometryPkg;

    // pixel column on the 160 wide screen
    typedef logic [7:0] xCoordT;

    // pixel row on the 120 high screen
    typedef logic [6:0] yCoordT;

    // visible area in pixels
    localparam int ScreenWidth  = 160;
    localparam int ScreenHeight = 120;

    // head block top-left after reset
    localparam int StartX = 80;
    localparam int StartY = 60;

    // fixed apple block, never eaten
    localparam int AppleX = 30;
    localparam int AppleY = 30;

    // latched heading of the snake
    typedef enum logic [1:0]
    {
        dirUp,
        dirDown,
        dirLeft,
        dirRight
    } directionT;

endpackage

// File: src/snakeRenderPkg.sv
/*
 * Drawing definitions for the frame renderer: colour type, the fixed
 * colours and the frame state machine encoding.
 */
package snakeRenderPkg;

    // 3 bit rgb, one bit per channel
    typedef logic [2:0] colourT;

    // red apple, black for erasing
    localparam int AppleColour = 4;
    localparam int EraseColour = 0;

    // frame phases, in the order a normal frame walks them
    typedef enum logic [2:0]
    {
        waitStart,
        drawApple,
        drawBody,
        waitTick,
        eraseBody,
        checkHit,
        stepSnake,
        gameEnded
    } renderStateT;

endpackage

// File: src/headSteering.sv
/*
 * Steering of the snake head. Latches a direction from four key levels,
 * holds the head block and offers the next block plus a wall flag.
 */
`timescale 1ns/1ps

module headSteering
#(
    parameter int BlockSize = 10
)
(
    input  logic                      Clock,
    input  logic                      reset,
    input  logic                      keyRight,
    input  logic                      keyDown,
    input  logic                      keyUp,
    input  logic                      keyLeft,
    input  logic                      stepPulse,
    output snakeGeometryPkg::xCoordT  headX,
    output snakeGeometryPkg::yCoordT  headY,
    output snakeGeometryPkg::xCoordT  nextHeadX,
    output snakeGeometryPkg::yCoordT  nextHeadY,
    output logic                      offScreen
);
    import snakeGeometryPkg::*;

    directionT direction;

    // signed copies so a step past column or row 0 goes negative
    int nextXInt;
    int nextYInt;

    // fixed priority right, down, up, left
    // no key held keeps the old heading
    always_ff @(posedge Clock)
    begin
        if (reset)
            direction <= dirUp;
        else if (keyRight)
            direction <= dirRight;
        else if (keyDown)
            direction <= dirDown;
        else if (keyUp)
            direction <= dirUp;
        else if (keyLeft)
            direction <= dirLeft;
    end

    // one block ahead in the current heading
    always_comb
    begin
        nextXInt = int'(headX);
        nextYInt = int'(headY);
        case (direction)
            dirUp:    nextYInt = int'(headY) - BlockSize;
            dirDown:  nextYInt = int'(headY) + BlockSize;
            dirLeft:  nextXInt = int'(headX) - BlockSize;
            default:  nextXInt = int'(headX) + BlockSize;
        endcase
    end

    assign nextHeadX = xCoordT'(nextXInt);
    assign nextHeadY = yCoordT'(nextYInt);

    // block must fit entirely on screen
    assign offScreen = (nextXInt < 0) || (nextXInt > ScreenWidth - BlockSize) ||
                       (nextYInt < 0) || (nextYInt > ScreenHeight - BlockSize);

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            headX <= xCoordT'(StartX);
            headY <= yCoordT'(StartY);
        end
        else if (stepPulse)
        begin
            headX <= nextHeadX;
            headY <= nextHeadY;
        end
    end

    // the renderer must never step the head into a wall
    assert property (@(posedge Clock) disable iff (reset) stepPulse |-> !offScreen);

endmodule

// File: src/bodySegment.sv
/*
 * One body block of the snake. Follows its predecessor on each step and
 * flags when the head is about to move onto it.
 */
`timescale 1ns/1ps

module bodySegment
#(
    parameter int SegmentIndex = 1,
    parameter int BlockSize    = 10
)
(
    input  logic                      Clock,
    input  logic                      reset,
    input  logic                      stepPulse,
    input  snakeGeometryPkg::xCoordT  predX,
    input  snakeGeometryPkg::yCoordT  predY,
    input  snakeGeometryPkg::xCoordT  nextHeadX,
    input  snakeGeometryPkg::yCoordT  nextHeadY,
    output snakeGeometryPkg::xCoordT  segX,
    output snakeGeometryPkg::yCoordT  segY,
    output logic                      bodyHit
);
    import snakeGeometryPkg::*;

    // start column under the head, rows stacked downward
    localparam int SegStartY = StartY + SegmentIndex * BlockSize;

    // shift along the chain, predecessor's old block becomes ours
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            segX <= xCoordT'(StartX);
            segY <= yCoordT'(SegStartY);
        end
        else if (stepPulse)
        begin
            segX <= predX;
            segY <= predY;
        end
    end

    // blocks sit on a BlockSize grid, so equal corners mean overlap
    assign bodyHit = (segX == nextHeadX) && (segY == nextHeadY);

endmodule

// File: src/frameRenderer.sv
/*
 * Frame sequencer. Paces the game with a free running tick, draws apple and
 * snake, erases the snake, checks for a collision and steps the snake.
 */
`timescale 1ns/1ps

module frameRenderer
#(
    parameter int BlockSize    = 10,
    parameter int SnakeLength  = 6,
    parameter int TicksPerStep = 1000000
)
(
    input  logic                      Clock,
    input  logic                      reset,
    input  logic                      go,
    input  snakeRenderPkg::colourT    snakeColour,
    input  snakeGeometryPkg::xCoordT  headX,
    input  snakeGeometryPkg::yCoordT  headY,
    input  snakeGeometryPkg::xCoordT  segX [1:SnakeLength-1],
    input  snakeGeometryPkg::yCoordT  segY [1:SnakeLength-1],
    input  logic [SnakeLength-2:0]    bodyHit,
    input  logic                      offScreen,
    output logic                      stepPulse,
    output snakeGeometryPkg::xCoordT  pixelX,
    output snakeGeometryPkg::yCoordT  pixelY,
    output snakeRenderPkg::colourT    pixelColour,
    output logic                      plot,
    output logic                      gameOver
);
    import snakeGeometryPkg::*;
    import snakeRenderPkg::*;

    localparam int TickWidth = (TicksPerStep > 1) ? $clog2(TicksPerStep) : 1;
    localparam int BlockCountWidth = (SnakeLength > 1) ? $clog2(SnakeLength) : 1;

    renderStateT state;
    renderStateT nextState;

    logic [TickWidth-1:0]       tickCount;
    logic                       tick;
    logic [BlockCountWidth-1:0] blockCount;
    logic                       lastBlock;
    xCoordT                     offX;
    yCoordT                     offY;
    logic                       lastPixel;
    logic                       collision;

    // block corners, head first
    xCoordT cornerX [SnakeLength];
    yCoordT cornerY [SnakeLength];

    always_ff @(posedge Clock)
    begin
        if (reset || tick)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    assign tick = (tickCount == TickWidth'(TicksPerStep - 1));

    always_comb
    begin
        cornerX[0] = headX;
        cornerY[0] = headY;
        for (int i = 1; i < SnakeLength; i++)
        begin
            cornerX[i] = segX[i];
            cornerY[i] = segY[i];
        end
    end

    assign lastPixel = (offX == xCoordT'(BlockSize - 1)) && (offY == yCoordT'(BlockSize - 1));
    assign lastBlock = (blockCount == BlockCountWidth'(SnakeLength - 1));

    // tail leaves its block on the same step, so its bit is not counted
    assign collision = offScreen || (|bodyHit[SnakeLength-3:0]);

    always_comb
    begin
        nextState = state;
        case (state)
            waitStart: if (tick && go) nextState = drawApple;
            drawApple: if (lastPixel) nextState = drawBody;
            drawBody:  if (lastPixel && lastBlock) nextState = waitTick;
            waitTick:  if (tick) nextState = eraseBody;
            eraseBody: if (lastPixel && lastBlock) nextState = checkHit;
            checkHit:  nextState = collision ? gameEnded : stepSnake;
            // keys may turn the head after checkHit, so check again here
            stepSnake: nextState = collision ? gameEnded : drawApple;
            default:   nextState = gameEnded;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            state      <= waitStart;
            blockCount <= '0;
            offX       <= '0;
            offY       <= '0;
        end
        else
        begin
            state <= nextState;
            if (plot)
            begin
                // row-major walk inside the block
                if (offX == xCoordT'(BlockSize - 1))
                begin
                    offX <= '0;
                    offY <= (offY == yCoordT'(BlockSize - 1)) ? '0 : offY + 1'b1;
                end
                else
                    offX <= offX + 1'b1;
                // next snake block once a whole block is written
                if (state != drawApple && lastPixel)
                    blockCount <= lastBlock ? '0 : blockCount + 1'b1;
            end
        end
    end

    assign plot      = (state == drawApple) || (state == drawBody) || (state == eraseBody);
    assign stepPulse = (state == stepSnake) && !collision;
    assign gameOver  = (state == gameEnded);

    always_comb
    begin
        if (state == drawApple)
        begin
            pixelX      = xCoordT'(AppleX) + offX;
            pixelY      = yCoordT'(AppleY) + offY;
            pixelColour = colourT'(AppleColour);
        end
        else
        begin
            pixelX      = cornerX[blockCount] + offX;
            pixelY      = cornerY[blockCount] + offY;
            pixelColour = (state == eraseBody) ? colourT'(EraseColour) : snakeColour;
        end
    end

    // pixel writes never leave the visible screen
    assert property (@(posedge Clock) disable iff (reset)
        plot |-> (int'(pixelX) < ScreenWidth) && (int'(pixelY) < ScreenHeight));

    // offsets are back at the block corner whenever no pass is running
    assert property (@(posedge Clock) disable iff (reset)
        !plot |-> (offX == '0) && (offY == '0));

endmodule

// File: src/snakeGame.sv
/*
 * Snake game engine top level. Chains the head steering into the body
 * segments and hands all positions to the renderer, which emits pixel writes.
 */
`timescale 1ns/1ps

module snakeGame
#(
    parameter int BlockSize    = 10,
    parameter int SnakeLength  = 6,
    parameter int TicksPerStep = 1000000
)
(
    input  logic                      Clock,
    input  logic                      reset,
    input  logic                      go,
    input  logic                      keyRight,
    input  logic                      keyDown,
    input  logic                      keyUp,
    input  logic                      keyLeft,
    input  snakeRenderPkg::colourT    snakeColour,
    output snakeGeometryPkg::xCoordT  pixelX,
    output snakeGeometryPkg::yCoordT  pixelY,
    output snakeRenderPkg::colourT    pixelColour,
    output logic                      plot,
    output logic                      gameOver
);
    import snakeGeometryPkg::*;

    xCoordT headX;
    yCoordT headY;
    xCoordT nextHeadX;
    yCoordT nextHeadY;
    logic   offScreen;
    logic   stepPulse;

    // body blocks behind the head, index 1 right after it
    xCoordT                segX [1:SnakeLength-1];
    yCoordT                segY [1:SnakeLength-1];
    logic [SnakeLength-2:0] bodyHit;

    headSteering #(
        .BlockSize (BlockSize)
    ) i_headSteering (
        .Clock     (Clock),
        .reset     (reset),
        .keyRight  (keyRight),
        .keyDown   (keyDown),
        .keyUp     (keyUp),
        .keyLeft   (keyLeft),
        .stepPulse (stepPulse),
        .headX     (headX),
        .headY     (headY),
        .nextHeadX (nextHeadX),
        .nextHeadY (nextHeadY),
        .offScreen (offScreen)
    );

    for (genvar g = 1; g < SnakeLength; g++)
    begin : segmentLoop
        xCoordT predX;
        yCoordT predY;

        // first segment follows the head, the rest follow each other
        if (g == 1)
        begin : fromHead
            assign predX = headX;
            assign predY = headY;
        end
        else
        begin : fromSegment
            assign predX = segX[g-1];
            assign predY = segY[g-1];
        end

        bodySegment #(
            .SegmentIndex (g),
            .BlockSize    (BlockSize)
        ) i_bodySegment (
            .Clock     (Clock),
            .reset     (reset),
            .stepPulse (stepPulse),
            .predX     (predX),
            .predY     (predY),
            .nextHeadX (nextHeadX),
            .nextHeadY (nextHeadY),
            .segX      (segX[g]),
            .segY      (segY[g]),
            .bodyHit   (bodyHit[g-1])
        );
    end

    frameRenderer #(
        .BlockSize    (BlockSize),
        .SnakeLength  (SnakeLength),
        .TicksPerStep (TicksPerStep)
    ) i_frameRenderer (
        .Clock       (Clock),
        .reset       (reset),
        .go          (go),
        .snakeColour (snakeColour),
        .headX       (headX),
        .headY       (headY),
        .segX        (segX),
        .segY        (segY),
        .bodyHit     (bodyHit),
        .offScreen   (offScreen),
        .stepPulse   (stepPulse),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .pixelColour (pixelColour),
        .plot        (plot),
        .gameOver    (gameOver)
    );

endmodule

// File: testbench/snakeChecks.svh
/*
 * Typed compare tasks and check counters for the snake game testbench.
 * Included inside the testbench module, after the package imports.
 */
`ifndef SNAKE_CHECKS_SVH
`define SNAKE_CHECKS_SVH

// totals over the whole run
int checkCount = 0;
int errorCount = 0;

task automatic checkX(input xCoordT actual, input xCoordT expected, input string what);
    checkCount++;
    if (actual !== expected)
    begin
        errorCount++;
        $display("FAILED at %0t: %s column %0d, expected %0d", $time, what, actual, expected);
    end
endtask

task automatic checkY(input yCoordT actual, input yCoordT expected, input string what);
    checkCount++;
    if (actual !== expected)
    begin
        errorCount++;
        $display("FAILED at %0t: %s row %0d, expected %0d", $time, what, actual, expected);
    end
endtask

task automatic checkColour(input colourT actual, input colourT expected, input string what);
    checkCount++;
    if (actual !== expected)
    begin
        errorCount++;
        $display("FAILED at %0t: %s colour %0d, expected %0d", $time, what, actual, expected);
    end
endtask

task automatic checkFlag(input logic actual, input logic expected, input string what);
    checkCount++;
    if (actual !== expected)
    begin
        errorCount++;
        $display("FAILED at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
endtask

// failures that are not a wrong value, e.g. a missing pass
task automatic noteProblem(input string message);
    errorCount++;
    $display("%s (at %0t)", message, $time);
endtask

`endif

// File: testbench/snakeGameTb.sv
/*
 * Testbench for the snake game engine. Replays key patterns from a data file,
 * follows every pixel pass against a body model and checks head and game end.
 */
`timescale 1ns/1ps

module snakeGameTb;
    import snakeGeometryPkg::*;
    import snakeRenderPkg::*;

    localparam int BlockSize    = 2;
    localparam int SnakeLength  = 6;
    localparam int TicksPerStep = 64;
    localparam int ClockPeriod  = 10;
    // tick wait plus apple, 6 draw and 6 erase blocks
    localparam int FrameCycles  = TicksPerStep + 13 * BlockSize * BlockSize;

    logic   Clock;
    logic   reset;
    logic   go;
    logic   keyRight;
    logic   keyDown;
    logic   keyUp;
    logic   keyLeft;
    colourT snakeColour;
    xCoordT pixelX;
    yCoordT pixelY;
    colourT pixelColour;
    logic   plot;
    logic   gameOver;

    `include "snakeChecks.svh"

    // pattern columns, one entry per step
    logic [3:0] patKeys [$];
    int         patX [$];
    int         patY [$];
    logic       patGo [$];
    int         lineCount;
    bit         patternsLoaded = 1'b0;

    // expected block corners, head first
    xCoordT modelX [SnakeLength];
    yCoordT modelY [SnakeLength];
    xCoordT drawnHeadX;
    yCoordT drawnHeadY;

    snakeGame #(
        .BlockSize    (BlockSize),
        .SnakeLength  (SnakeLength),
        .TicksPerStep (TicksPerStep)
    ) i_snakeGame (
        .Clock       (Clock),
        .reset       (reset),
        .go          (go),
        .keyRight    (keyRight),
        .keyDown     (keyDown),
        .keyUp       (keyUp),
        .keyLeft     (keyLeft),
        .snakeColour (snakeColour),
        .pixelX      (pixelX),
        .pixelY      (pixelY),
        .pixelColour (pixelColour),
        .plot        (plot),
        .gameOver    (gameOver)
    );

    initial
    begin
        Clock = 1'b0;
        forever #(ClockPeriod / 2) Clock = ~Clock;
    end

    function automatic int unsigned lcgNext(input int unsigned state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // start column, rows stacked below the head
    function automatic void resetModel();
        for (int i = 0; i < SnakeLength; i++)
        begin
            modelX[i] = xCoordT'(StartX);
            modelY[i] = yCoordT'(StartY + i * BlockSize);
        end
    endfunction

    function automatic void shiftModel(input xCoordT x, input yCoordT y);
        for (int i = SnakeLength - 1; i > 0; i--)
        begin
            modelX[i] = modelX[i-1];
            modelY[i] = modelY[i-1];
        end
        modelX[0] = x;
        modelY[0] = y;
    endfunction

    task automatic readPatterns();
        int    fd;
        int    items;
        string line;
        logic  kr;
        logic  kd;
        logic  ku;
        logic  kl;
        int    x;
        int    y;
        logic  g;
        fd = $fopen("testbench/snakePatterns.txt", "r");
        if (fd == 0)
        begin
            noteProblem("could not open the pattern file");
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            // skip comments and blank lines
            if (line.len() < 2 || line.getc(0) == "#")
                continue;
            items = $sscanf(line, "%b %b %b %b %d %d %b", kr, kd, ku, kl, x, y, g);
            if (items == 7)
            begin
                patKeys.push_back({kr, kd, ku, kl});
                patX.push_back(x);
                patY.push_back(y);
                patGo.push_back(g);
            end
        end
        $fclose(fd);
    endtask

    task automatic applyReset();
        @(posedge Clock);
        #1;
        reset = 1'b1;
        go = 1'b0;
        {keyRight, keyDown, keyUp, keyLeft} = 4'b0000;
        repeat (10) @(posedge Clock);
        #1;
        reset = 1'b0;
    endtask

    // follows one pass pixel by pixel, apple first when drawing
    task automatic capturePass(input bit isDraw, input string passName);
        int     waited;
        int     p;
        colourT bodyColour;
        waited = 0;
        bodyColour = isDraw ? snakeColour : colourT'(EraseColour);
        while (!plot && waited < 2 * FrameCycles)
        begin
            @(negedge Clock);
            waited++;
        end
        if (!plot)
        begin
            noteProblem({"the ", passName, " pass never started"});
            return;
        end
        if (isDraw)
        begin
            for (p = 0; p < BlockSize * BlockSize; p++)
            begin
                checkX(pixelX, xCoordT'(AppleX + p % BlockSize), "apple pixel");
                checkY(pixelY, yCoordT'(AppleY + p / BlockSize), "apple pixel");
                checkColour(pixelColour, colourT'(AppleColour), "apple pixel");
                checkFlag(plot, 1'b1, "apple plot");
                @(negedge Clock);
            end
        end
        for (int b = 0; b < SnakeLength; b++)
        begin
            for (p = 0; p < BlockSize * BlockSize; p++)
            begin
                if (isDraw && b == 0 && p == 0)
                begin
                    drawnHeadX = pixelX;
                    drawnHeadY = pixelY;
                end
                checkX(pixelX, xCoordT'(modelX[b] + p % BlockSize), $sformatf("%s block %0d", passName, b));
                checkY(pixelY, yCoordT'(modelY[b] + p / BlockSize), $sformatf("%s block %0d", passName, b));
                checkColour(pixelColour, bodyColour, $sformatf("%s block %0d", passName, b));
                checkFlag(plot, 1'b1, {passName, " plot"});
                @(negedge Clock);
            end
        end
        checkFlag(plot, 1'b0, {passName, " plot after the last block"});
    endtask

    // idle check before go, then the first draw pass
    task automatic startGame();
        int sawPlot;
        int sawOver;
        sawPlot = 0;
        sawOver = 0;
        resetModel();
        repeat (2 * TicksPerStep)
        begin
            @(negedge Clock);
            if (plot)
                sawPlot++;
            if (gameOver)
                sawOver++;
        end
        checkFlag(sawPlot != 0, 1'b0, "plot before go");
        checkFlag(sawOver != 0, 1'b0, "gameOver before go");
        @(posedge Clock);
        #1;
        go = 1'b1;
        capturePass(1'b1, "first draw");
    endtask

    // keys go in while waiting for the tick, so the step sees them
    task automatic runStep(input int n);
        int waited;
        int sawPlot;
        waited = 0;
        sawPlot = 0;
        @(posedge Clock);
        #1;
        {keyRight, keyDown, keyUp, keyLeft} = patKeys[n];
        capturePass(1'b0, "erase");
        while (!plot && !gameOver && waited < 8)
        begin
            @(negedge Clock);
            waited++;
        end
        if (plot)
        begin
            shiftModel(xCoordT'(patX[n]), yCoordT'(patY[n]));
            capturePass(1'b1, "draw");
            checkX(drawnHeadX, xCoordT'(patX[n]), "head after step");
            checkY(drawnHeadY, yCoordT'(patY[n]), "head after step");
            checkFlag(gameOver, patGo[n], "gameOver while drawing");
        end
        else if (gameOver)
        begin
            checkFlag(gameOver, patGo[n], "gameOver after erase");
            checkX(drawnHeadX, xCoordT'(patX[n]), "last drawn head");
            checkY(drawnHeadY, yCoordT'(patY[n]), "last drawn head");
            // frozen: no writes, flag held
            repeat (2 * FrameCycles)
            begin
                @(negedge Clock);
                if (plot)
                    sawPlot++;
            end
            checkFlag(sawPlot != 0, 1'b0, "plot after game over");
            checkFlag(gameOver, 1'b1, "gameOver held");
        end
        else
            noteProblem("neither a new frame nor game over followed the erase pass");
    endtask

    initial
    begin
        int unsigned seed;
        int          errorsBefore;
        int          testCount;
        bit          needStart;
        reset = 1'b1;
        go = 1'b0;
        {keyRight, keyDown, keyUp, keyLeft} = 4'b0000;
        // snake colour must differ from apple and erase colours
        seed = 92062;
        do
        begin
            seed = lcgNext(seed);
            snakeColour = colourT'(seed >> 16);
        end
        while (snakeColour == colourT'(EraseColour) || snakeColour == colourT'(AppleColour));
        testCount = 0;
        needStart = 1'b1;
        readPatterns();
        lineCount = patKeys.size();
        if (lineCount == 0)
            noteProblem("no pattern lines were read");
        patternsLoaded = 1'b1;
        for (int n = 0; n < lineCount; n++)
        begin
            // a finished game only clears through reset
            if (needStart)
            begin
                errorsBefore = errorCount;
                applyReset();
                startGame();
                testCount++;
                $display("test start: idle before go and first draw pass, %s",
                         (errorCount == errorsBefore) ? "ok" : "mismatch");
                needStart = 1'b0;
            end
            errorsBefore = errorCount;
            runStep(n);
            testCount++;
            $display("test %0d: keys %b, head %0d,%0d, gameOver %b, %s", n + 1, patKeys[n],
                     patX[n], patY[n], patGo[n], (errorCount == errorsBefore) ? "ok" : "mismatch");
            if (patGo[n])
                needStart = 1'b1;
        end
        $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // watchdog, two frames per pattern line plus slack for resets
    initial
    begin
        int limitCycles;
        wait (patternsLoaded);
        limitCycles = lineCount * 2 * FrameCycles + 20 * FrameCycles;
        #(limitCycles * ClockPeriod);
        $display("the simulation timed out after %0d cycles", limitCycles);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: testbench/snakePatterns.txt
# keys right down up left, expected head x and y after the step, expected gameOver
# a line with gameOver 1 ends a game, the next line starts from a fresh reset
0 0 0 0 80 58 0
0 0 0 0 80 56 0
1 0 0 0 82 56 0
1 1 0 0 84 56 0
0 0 1 1 84 54 0
0 0 0 1 82 54 0
0 0 0 0 80 54 0
0 1 1 1 80 56 0
0 0 1 0 80 56 1
0 0 0 1 78 60 0
0 0 0 0 76 60 0
0 0 0 0 74 60 0
0 0 0 0 72 60 0
0 0 0 0 70 60 0
0 0 0 0 68 60 0
0 0 0 0 66 60 0
0 0 0 0 64 60 0
0 0 0 0 62 60 0
0 0 0 0 60 60 0
0 0 0 0 58 60 0
0 0 0 0 56 60 0
0 0 0 0 54 60 0
0 0 0 0 52 60 0
0 0 0 0 50 60 0
0 0 0 0 48 60 0
0 0 0 0 46 60 0
0 0 0 0 44 60 0
0 0 0 0 42 60 0
0 0 0 0 40 60 0
0 0 0 0 38 60 0
0 0 0 0 36 60 0
0 0 0 0 34 60 0
0 0 0 0 32 60 0
0 0 0 0 30 60 0
0 0 0 0 28 60 0
0 0 0 0 26 60 0
0 0 0 0 24 60 0
0 0 0 0 22 60 0
0 0 0 0 20 60 0
0 0 0 0 18 60 0
0 0 0 0 16 60 0
0 0 0 0 14 60 0
0 0 0 0 12 60 0
0 0 0 0 10 60 0
0 0 0 0 8 60 0
0 0 0 0 6 60 0
0 0 0 0 4 60 0
0 0 0 0 2 60 0
0 0 0 0 0 60 0
0 0 0 0 0 60 1

// File: snakeGame.f
+incdir+testbench
src/snakeGeometryPkg.sv
src/snakeRenderPkg.sv
src/headSteering.sv
src/bodySegment.sv
src/frameRenderer.sv
src/snakeGame.sv
testbench/snakeGameTb.sv

// File: Bender.yml
package:
  name: snake_game

sources:
  - src/snakeGeometryPkg.sv
  - src/snakeRenderPkg.sv
  - src/headSteering.sv
  - src/bodySegment.sv
  - src/frameRenderer.sv
  - src/snakeGame.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/snakeGameTb.sv
